//--- include/trace_consts.svh
/*
 * Constants shared by the trace unit RTL. TRACE_FIFO_DEPTH must be a
 * power of two, and TRACE_LEVEL_W must stay at log2(depth) + 1.
 * Register offsets are 12-bit byte offsets within the APB window.
 */
`ifndef TRACE_CONSTS_SVH
`define TRACE_CONSTS_SVH

// Record buffer sizing
`define TRACE_FIFO_DEPTH 8
`define TRACE_LEVEL_W    4

// Saturating dropped-record counter
`define TRACE_DROP_W     16

// APB register map
`define TRACE_REG_CTRL   12'h000
`define TRACE_REG_STATUS 12'h004
`define TRACE_REG_PC     12'h008
`define TRACE_REG_INFO   12'h00C

`endif

//--- hw/trace_pkg.sv
/*
 * Trace record types. The info word of a record is read through the
 * insn view for plain retirements and the evt view when is_event is set.
 */
package trace_pkg;

  // Event view of the info word, 32 bits
  typedef struct packed {
    logic        trap;
    logic        intr;
    logic        halt;
    logic [1:0]  mode;
    logic [4:0]  rd_addr;
    logic [21:0] order;   // low bits of rvfi_order only
  } trace_event_t;

  // One word, two decodings
  typedef union packed {
    logic [31:0]  insn;
    trace_event_t evt;
  } trace_info_u;

  // Full record as stored in the FIFO, 65 bits
  typedef struct packed {
    logic        is_event;
    logic [31:0] pc;
    trace_info_u info;
  } trace_rec_t;

endpackage

//--- hw/trace_encoder.sv
/*
 * Registers one record per retirement while capture is enabled.
 * The core cannot be stalled, so a record that meets a full FIFO is lost
 * and counted; the counter saturates and a clear wins over a count.
 */
`timescale 1ns/100ps
`include "trace_consts.svh"

module trace_encoder import trace_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_i,

  // Retirement port from the core
  input  logic                     rvfi_valid_i,
  input  logic [63:0]              rvfi_order_i,
  input  logic [31:0]              rvfi_insn_i,
  input  logic                     rvfi_trap_i,
  input  logic                     rvfi_halt_i,
  input  logic                     rvfi_intr_i,
  input  logic [1:0]               rvfi_mode_i,
  input  logic [4:0]               rvfi_rd_addr_i,
  input  logic [31:0]              rvfi_pc_rdata_i,

  // Control from the APB port
  input  logic                     trace_en_i,
  input  logic                     drop_clr_i,

  // FIFO write side
  input  logic                     full_i,
  output logic                     push_o,
  output trace_rec_t               push_rec_o,

  output logic [`TRACE_DROP_W-1:0] drop_cnt_o
);

  trace_rec_t               rec_d;
  trace_rec_t               rec_q;
  logic                     rec_valid_q;
  logic [`TRACE_DROP_W-1:0] drop_cnt_q;

  // Build the record from the current retirement
  always_comb begin
    rec_d          = '0;
    rec_d.is_event = rvfi_trap_i | rvfi_intr_i | rvfi_halt_i;
    rec_d.pc       = rvfi_pc_rdata_i;
    if (rec_d.is_event) begin
      rec_d.info.evt.trap    = rvfi_trap_i;
      rec_d.info.evt.intr    = rvfi_intr_i;
      rec_d.info.evt.halt    = rvfi_halt_i;
      rec_d.info.evt.mode    = rvfi_mode_i;
      rec_d.info.evt.rd_addr = rvfi_rd_addr_i;
      rec_d.info.evt.order   = rvfi_order_i[21:0];
    end else begin
      rec_d.info.insn = rvfi_insn_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rec_valid_q <= 1'b0;
    end else begin
      rec_valid_q <= rvfi_valid_i & trace_en_i;
    end
  end

  // Payload only
  always_ff @(posedge clk_i) begin
    if (rvfi_valid_i) begin
      rec_q <= rec_d;
    end
  end

  // Lost records, saturating
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      drop_cnt_q <= '0;
    end else if (drop_clr_i) begin
      drop_cnt_q <= '0;
    end else if (rec_valid_q && full_i && (drop_cnt_q != '1)) begin
      drop_cnt_q <= drop_cnt_q + 1'b1;
    end
  end

  // Push one cycle after the retirement is sampled
  assign push_o     = rec_valid_q & ~full_i;
  assign push_rec_o = rec_q;
  assign drop_cnt_o = drop_cnt_q;

endmodule

//--- hw/trace_fifo.sv
/*
 * First-word-fall-through record FIFO. DEPTH must be a power of two
 * and at least 2. A push while full or a pop while empty is ignored.
 */
`timescale 1ns/100ps
`include "trace_consts.svh"

module trace_fifo import trace_pkg::*; #(
  parameter int unsigned DEPTH = `TRACE_FIFO_DEPTH
) (
  input  logic                   clk_i,
  input  logic                   rst_i,

  input  logic                   push_i,
  input  trace_rec_t             push_rec_i,
  input  logic                   pop_i,

  output trace_rec_t             head_rec_o,
  output logic                   empty_o,
  output logic                   full_o,
  output logic [$clog2(DEPTH):0] level_o
);

  localparam int unsigned PTR_W = $clog2(DEPTH);

  trace_rec_t       mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   count_q;
  logic             do_push;
  logic             do_pop;

  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_rec_i;
    end
  end

  // Pointers wrap naturally at a power-of-two depth
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  assign head_rec_o = mem_q[rd_ptr_q];
  assign empty_o    = (count_q == '0);
  assign full_o     = (count_q == DEPTH[PTR_W:0]);
  assign level_o    = count_q;

endmodule

//--- hw/trace_apb_port.sv
/*
 * APB slave for the trace unit. No wait states; paddr_i is the 12-bit
 * byte offset in the block and only exact offsets are mapped. Reading
 * INFO pops the head record; writes to read-only registers are ignored.
 */
`timescale 1ns/100ps
`include "trace_consts.svh"

module trace_apb_port import trace_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_i,

  // APB slave
  input  logic                      psel_i,
  input  logic                      penable_i,
  input  logic                      pwrite_i,
  input  logic [11:0]               paddr_i,
  input  logic [31:0]               pwdata_i,
  output logic [31:0]               prdata_o,
  output logic                      pready_o,
  output logic                      pslverr_o,

  // FIFO read side
  input  trace_rec_t                head_rec_i,
  input  logic                      empty_i,
  input  logic [`TRACE_LEVEL_W-1:0] level_i,
  output logic                      pop_o,

  // Encoder control
  input  logic [`TRACE_DROP_W-1:0]  drop_cnt_i,
  output logic                      trace_en_o,
  output logic                      drop_clr_o
);

  logic        access;
  logic        sel_ctrl;
  logic        sel_status;
  logic        sel_pc;
  logic        sel_info;
  logic        mapped;
  logic        ctrl_wr;
  logic        trace_en_q;
  logic [31:0] status_word;

  // Access phase of a transfer
  assign access = psel_i & penable_i;

  // Offset decode
  assign sel_ctrl   = (paddr_i == `TRACE_REG_CTRL);
  assign sel_status = (paddr_i == `TRACE_REG_STATUS);
  assign sel_pc     = (paddr_i == `TRACE_REG_PC);
  assign sel_info   = (paddr_i == `TRACE_REG_INFO);
  assign mapped     = sel_ctrl | sel_status | sel_pc | sel_info;

  assign ctrl_wr = access & pwrite_i & sel_ctrl;

  // Capture enable, CTRL bit 0
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      trace_en_q <= 1'b0;
    end else if (ctrl_wr) begin
      trace_en_q <= pwdata_i[0];
    end
  end

  // Clear pulse lands at the end of the access cycle, same as the write
  assign drop_clr_o = ctrl_wr & pwdata_i[1];
  assign trace_en_o = trace_en_q;

  // Pop only a real record
  assign pop_o = access & ~pwrite_i & sel_info & ~empty_i;

  // Unmapped offset, or INFO read with nothing to give
  assign pslverr_o = access & (~mapped | (~pwrite_i & sel_info & empty_i));
  assign pready_o  = 1'b1;

  // STATUS layout: drop count high, empty at bit 4, level low
  assign status_word = {drop_cnt_i,
                        {(32 - `TRACE_DROP_W - `TRACE_LEVEL_W - 1){1'b0}},
                        empty_i,
                        level_i};

  // Read mux
  always_comb begin
    prdata_o = '0;
    if (sel_ctrl) begin
      prdata_o[0] = trace_en_q;
    end else if (sel_status) begin
      prdata_o = status_word;
    end else if (sel_pc) begin
      // pc is halfword aligned, bit 0 carries the record kind
      prdata_o = {head_rec_i.pc[31:1], head_rec_i.is_event};
    end else if (sel_info) begin
      prdata_o = head_rec_i.info.insn;
    end
  end

endmodule

//--- hw/trace_unit_top.sv
/*
 * Retirement trace unit: encoder, record FIFO and APB read port.
 * A retirement sampled at edge N is readable over APB from edge N+2.
 */
`timescale 1ns/100ps
`include "trace_consts.svh"

module trace_unit_top import trace_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,

  // Retirement port from the core
  input  logic        rvfi_valid_i,
  input  logic [63:0] rvfi_order_i,
  input  logic [31:0] rvfi_insn_i,
  input  logic        rvfi_trap_i,
  input  logic        rvfi_halt_i,
  input  logic        rvfi_intr_i,
  input  logic [1:0]  rvfi_mode_i,
  input  logic [4:0]  rvfi_rd_addr_i,
  input  logic [31:0] rvfi_pc_rdata_i,

  // APB slave
  input  logic        psel_i,
  input  logic        penable_i,
  input  logic        pwrite_i,
  input  logic [11:0] paddr_i,
  input  logic [31:0] pwdata_i,
  output logic [31:0] prdata_o,
  output logic        pready_o,
  output logic        pslverr_o
);

  logic                      push;
  trace_rec_t                push_rec;
  logic                      full;
  logic                      empty;
  logic                      pop;
  trace_rec_t                head_rec;
  logic [`TRACE_LEVEL_W-1:0] level;
  logic                      trace_en;
  logic                      drop_clr;
  logic [`TRACE_DROP_W-1:0]  drop_cnt;

  trace_encoder u_trace_encoder (
    .clk_i,
    .rst_i,
    .rvfi_valid_i,
    .rvfi_order_i,
    .rvfi_insn_i,
    .rvfi_trap_i,
    .rvfi_halt_i,
    .rvfi_intr_i,
    .rvfi_mode_i,
    .rvfi_rd_addr_i,
    .rvfi_pc_rdata_i,
    .trace_en_i (trace_en),
    .drop_clr_i (drop_clr),
    .full_i     (full),
    .push_o     (push),
    .push_rec_o (push_rec),
    .drop_cnt_o (drop_cnt)
  );

  trace_fifo #(
    .DEPTH (`TRACE_FIFO_DEPTH)
  ) u_trace_fifo (
    .clk_i,
    .rst_i,
    .push_i     (push),
    .push_rec_i (push_rec),
    .pop_i      (pop),
    .head_rec_o (head_rec),
    .empty_o    (empty),
    .full_o     (full),
    .level_o    (level)
  );

  trace_apb_port u_trace_apb_port (
    .clk_i,
    .rst_i,
    .psel_i,
    .penable_i,
    .pwrite_i,
    .paddr_i,
    .pwdata_i,
    .prdata_o,
    .pready_o,
    .pslverr_o,
    .head_rec_i (head_rec),
    .empty_i    (empty),
    .level_i    (level),
    .pop_o      (pop),
    .drop_cnt_i (drop_cnt),
    .trace_en_o (trace_en),
    .drop_clr_o (drop_clr)
  );

endmodule

//--- verification/trace_clk_gen.sv
/*
 * Free-running 100 ns clock. Reset is held high for the first
 * 8 rising edges and is released with the 8th.
 */
`timescale 1ns/100ps

module trace_clk_gen (
  output logic clk_o,
  output logic rst_o
);

  localparam int HALF_PERIOD_NS = 50;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD_NS clk_o = ~clk_o;
  end

  initial begin
    rst_o <= 1'b1;
    repeat (8) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

//--- verification/trace_unit_assertions.sv
/*
 * Protocol checks on the record FIFO, bound into trace_fifo.
 * All but the reset check are off while rst_i is high.
 */
`timescale 1ns/100ps
`include "trace_consts.svh"

module trace_unit_assertions #(
  parameter int unsigned DEPTH = `TRACE_FIFO_DEPTH
) (
  input logic                      clk_i,
  input logic                      rst_i,
  input logic                      push_i,
  input logic                      pop_i,
  input logic                      empty_i,
  input logic                      full_i,
  input logic [`TRACE_LEVEL_W-1:0] level_i
);

  localparam logic [`TRACE_LEVEL_W-1:0] DEPTH_L = DEPTH[`TRACE_LEVEL_W-1:0];

  int fail_cnt = 0;

  a_no_push_full: assert property (@(posedge clk_i) disable iff (rst_i) !(push_i && full_i))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("push offered while the FIFO is full");
    end

  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (rst_i) !(pop_i && empty_i))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("pop offered while the FIFO is empty");
    end

  a_level_bound: assert property (@(posedge clk_i) disable iff (rst_i) level_i <= DEPTH_L)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("FIFO level above its depth");
    end

  // Buffer comes out of reset empty
  a_reset_empty: assert property (@(posedge clk_i) rst_i |=> empty_i)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("FIFO not empty after reset");
    end

endmodule

//--- verification/trace_unit_tb.sv
/*
 * Testbench for trace_unit_top. Retirement bursts and APB drains never
 * overlap, so the model queue sees the same fill as the DUT FIFO.
 */
`timescale 1ns/100ps
`include "trace_consts.svh"

module trace_unit_tb import trace_pkg::*; ();

  localparam int ROUNDS          = 80;
  localparam int ROUND_CYCLES    = 100;
  localparam int DIRECTED_CYCLES = 300;
  localparam int CLK_PERIOD_NS   = 100;

  logic        clk_i;
  logic        rst_i;
  logic        rvfi_valid_i;
  logic [63:0] rvfi_order_i;
  logic [31:0] rvfi_insn_i;
  logic        rvfi_trap_i;
  logic        rvfi_halt_i;
  logic        rvfi_intr_i;
  logic [1:0]  rvfi_mode_i;
  logic [4:0]  rvfi_rd_addr_i;
  logic [31:0] rvfi_pc_rdata_i;
  logic        psel_i;
  logic        penable_i;
  logic        pwrite_i;
  logic [11:0] paddr_i;
  logic [31:0] pwdata_i;
  logic [31:0] prdata_o;
  logic        pready_o;
  logic        pslverr_o;

  // Reference model
  trace_rec_t               model_q[$];
  logic [`TRACE_DROP_W-1:0] model_drop;
  logic                     model_en;
  logic [63:0]              order_cnt;
  integer                   seed = 32'h898b_1d09;

  trace_clk_gen u_clk_gen (.clk_o(clk_i), .rst_o(rst_i));

  trace_unit_top DUT (.*);

  bind trace_fifo trace_unit_assertions #(.DEPTH(`TRACE_FIFO_DEPTH)) u_fifo_checks (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (push_i),
    .pop_i   (pop_i),
    .empty_i (empty_o),
    .full_i  (full_o),
    .level_i (level_o)
  );

  initial begin
    #((ROUNDS * ROUND_CYCLES + DIRECTED_CYCLES) * CLK_PERIOD_NS);
    $display("Timeout: the test sequence did not finish in time");
    $display("ERRORS FOUND");
    $fatal;
  end

  task automatic check(input string name, input logic [31:0] exp_val,
                       input logic [31:0] got_val);
    assert (got_val === exp_val) else begin
      $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp_val, got_val);
      $display("ERRORS FOUND");
      $fatal;
    end
  endtask

  // One APB transfer with no idle cycle in front
  task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    @(posedge clk_i);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= wr;
    paddr_i   <= addr;
    pwdata_i  <= wdata;
    @(posedge clk_i);
    penable_i <= 1'b1;
    // Sample in the middle of the access cycle
    @(negedge clk_i);
    rdata = prdata_o;
    err   = pslverr_o;
    // No wait states ever
    check("pready_o", 32'h1, {31'b0, pready_o});
    @(posedge clk_i);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
  endtask

  task automatic read_check(input string name, input logic [11:0] addr,
                            input logic [31:0] exp_val, input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    apb_xfer(1'b0, addr, 32'h0, rdata, err);
    check("pslverr_o", {31'b0, exp_err}, {31'b0, err});
    if (!exp_err) begin
      check(name, exp_val, rdata);
    end
  endtask

  task automatic write_ctrl(input logic [31:0] value);
    logic [31:0] rdata;
    logic        err;
    apb_xfer(1'b1, `TRACE_REG_CTRL, value, rdata, err);
    check("pslverr_o", 32'h0, {31'b0, err});
    model_en = value[0];
    if (value[1]) begin
      model_drop = '0;
    end
  endtask

  // STATUS: drop count in 31:16, empty in bit 4, level in 3:0
  function automatic logic [31:0] expected_status();
    int         n;
    logic [3:0] lvl;
    n   = model_q.size();
    lvl = n[3:0];
    return {model_drop, 11'b0, (n == 0), lvl};
  endfunction

  task automatic check_status();
    read_check("prdata_o STATUS", `TRACE_REG_STATUS, expected_status(), 1'b0);
  endtask

  // Drives one random retirement and updates the model
  task automatic drive_retirement();
    logic [31:0] r;
    logic [31:0] pc;
    logic [31:0] insn;
    logic [2:0]  kind;
    trace_rec_t  rec;
    r     = $random(seed);
    pc    = $random(seed);
    pc[0] = 1'b0;
    insn  = $random(seed);
    // About one in four is an event, with at least one flag set
    kind  = (r[1:0] == 2'b00) ? r[4:2] : 3'b000;
    if (r[1:0] == 2'b00 && kind == 3'b000) begin
      kind = 3'b001;
    end
    order_cnt = order_cnt + 64'd1;
    rvfi_valid_i    <= 1'b1;
    rvfi_order_i    <= order_cnt;
    rvfi_insn_i     <= insn;
    rvfi_trap_i     <= kind[0];
    rvfi_intr_i     <= kind[1];
    rvfi_halt_i     <= kind[2];
    rvfi_mode_i     <= r[6:5];
    rvfi_rd_addr_i  <= r[11:7];
    rvfi_pc_rdata_i <= pc;
    rec          = '0;
    rec.is_event = (kind != 3'b000);
    rec.pc       = pc;
    if (rec.is_event) begin
      rec.info.evt.trap    = kind[0];
      rec.info.evt.intr    = kind[1];
      rec.info.evt.halt    = kind[2];
      rec.info.evt.mode    = r[6:5];
      rec.info.evt.rd_addr = r[11:7];
      rec.info.evt.order   = order_cnt[21:0];
    end else begin
      rec.info.insn = insn;
    end
    if (model_en) begin
      if (model_q.size() < `TRACE_FIFO_DEPTH) begin
        model_q.push_back(rec);
      end else if (model_drop != '1) begin
        model_drop = model_drop + 1'b1;
      end
    end
  endtask

  task automatic offer_retirements(input int cycles, input logic dense);
    logic [31:0] r;
    for (int i = 0; i < cycles; i++) begin
      @(posedge clk_i);
      r = $random(seed);
      if (dense || r[0]) begin
        drive_retirement();
      end else begin
        rvfi_valid_i <= 1'b0;
      end
    end
    @(posedge clk_i);
    rvfi_valid_i <= 1'b0;
  endtask

  // PC then INFO, the INFO read pops the head
  task automatic read_record();
    logic [31:0] rdata;
    logic        err;
    trace_rec_t  rec;
    trace_info_u got;
    rec = model_q.pop_front();
    read_check("prdata_o PC", `TRACE_REG_PC, {rec.pc[31:1], rec.is_event}, 1'b0);
    apb_xfer(1'b0, `TRACE_REG_INFO, 32'h0, rdata, err);
    check("pslverr_o", 32'h0, {31'b0, err});
    got = rdata;
    if (rec.is_event) begin
      check("INFO evt.trap", {31'b0, rec.info.evt.trap}, {31'b0, got.evt.trap});
      check("INFO evt.intr", {31'b0, rec.info.evt.intr}, {31'b0, got.evt.intr});
      check("INFO evt.halt", {31'b0, rec.info.evt.halt}, {31'b0, got.evt.halt});
      check("INFO evt.mode", {30'b0, rec.info.evt.mode}, {30'b0, got.evt.mode});
      check("INFO evt.rd_addr", {27'b0, rec.info.evt.rd_addr}, {27'b0, got.evt.rd_addr});
      check("INFO evt.order", {10'b0, rec.info.evt.order}, {10'b0, got.evt.order});
    end else begin
      check("INFO insn", rec.info.insn, got.insn);
    end
  endtask

  task automatic drain(input int n);
    check_status();
    repeat (n) read_record();
    check_status();
  endtask

  initial begin
    logic [31:0] r;
    int          n;
    rvfi_valid_i    <= 1'b0;
    rvfi_order_i    <= '0;
    rvfi_insn_i     <= '0;
    rvfi_trap_i     <= 1'b0;
    rvfi_halt_i     <= 1'b0;
    rvfi_intr_i     <= 1'b0;
    rvfi_mode_i     <= '0;
    rvfi_rd_addr_i  <= '0;
    rvfi_pc_rdata_i <= '0;
    psel_i          <= 1'b0;
    penable_i       <= 1'b0;
    pwrite_i        <= 1'b0;
    paddr_i         <= '0;
    pwdata_i        <= '0;
    model_en   = 1'b0;
    model_drop = '0;
    order_cnt  = {$random(seed), $random(seed)};
    @(negedge rst_i);

    // Reset state, capture still off
    check_status();
    read_check("prdata_o CTRL", `TRACE_REG_CTRL, 32'h0, 1'b0);
    offer_retirements(6, 1'b1);
    check_status();

    write_ctrl(32'h1);
    read_check("prdata_o CTRL", `TRACE_REG_CTRL, 32'h1, 1'b0);
    // Empty INFO read and unmapped offset both error out
    read_check("prdata_o INFO", `TRACE_REG_INFO, 32'h0, 1'b1);
    read_check("prdata_o", 12'h010, 32'h0, 1'b1);
    check_status();

    // Overfill, then clear the drop count
    offer_retirements(12, 1'b1);
    check_status();
    write_ctrl(32'h3);
    // Clear bit reads back as 0
    read_check("prdata_o CTRL", `TRACE_REG_CTRL, 32'h1, 1'b0);
    drain(model_q.size());

    for (int i = 0; i < ROUNDS; i++) begin
      r = $random(seed);
      repeat (r[14:12]) @(posedge clk_i);
      offer_retirements(1 + int'(r[3:0]), r[7:4] == 4'h0);
      if (r[15:13] == 3'b000) begin
        write_ctrl(32'h3);
      end
      n = int'(r[11:8]);
      if (n > model_q.size()) begin
        n = model_q.size();
      end
      drain(n);
    end
    drain(model_q.size());

    if (DUT.u_trace_fifo.u_fifo_checks.fail_cnt != 0) begin
      $display("FIFO assertion failures: %0d", DUT.u_trace_fifo.u_fifo_checks.fail_cnt);
      $display("ERRORS FOUND");
      $fatal;
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

//--- trace_unit_top.f
+incdir+include
hw/trace_pkg.sv
hw/trace_encoder.sv
hw/trace_fifo.sv
hw/trace_apb_port.sv
hw/trace_unit_top.sv
verification/trace_clk_gen.sv
verification/trace_unit_assertions.sv
verification/trace_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the trace unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module trace_unit_tb \
  -f trace_unit_top.f --Mdir obj_dir -o trace_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Keep running past a failed concurrent assertion so the testbench can report it
./obj_dir/trace_sim +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "NO ERRORS" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1
